// File: logic/ccx_mem_pkg.sv
// ====================
// Shared definitions for the client memory subsystem: line sizes,
// read and write request headers, MMIO request and response words,
// the control register layout and the register offsets
// ====================

`default_nettype none

package ccx_mem_pkg;

    // ====================
    // Line geometry
    // ====================

    // 64 lines of local storage, each one 64-bit word
    localparam int line_addr_w = 6;
    localparam int line_data_w = 64;

    typedef logic [line_addr_w-1:0] line_addr_t;
    typedef logic [line_data_w-1:0] line_data_t;

    // ====================
    // Request headers
    // ====================

    // Read header, 7 bits
    // check_order holds the read until every earlier write has landed
    typedef struct packed {
        line_addr_t addr;
        logic       check_order;
    } rd_req_t;

    // Write header with its payload, 71 bits
    typedef struct packed {
        line_addr_t addr;
        line_data_t data;
        logic       check_order;
    } wr_req_t;

    // ====================
    // MMIO
    // ====================

    // MMIO request word, 35 bits, qualified by a separate valid strobe
    typedef struct packed {
        logic [1:0]  offset;
        logic [31:0] wdata;
        logic        is_write;
    } mmio_req_t;

    // Registered MMIO read data, qualified by its own valid pulse
    typedef struct packed {
        logic [31:0] data;
    } mmio_rsp_t;

    // Register offsets
    localparam logic [1:0] csr_ctrl    = 2'd0;
    localparam logic [1:0] csr_wr_acks = 2'd1;
    localparam logic [1:0] csr_rd_rsps = 2'd2;

    // Control register, enable sits in bit 0
    typedef struct packed {
        logic [29:0] reserved;
        logic        force_order;
        logic        enable;
    } ctrl_t;

endpackage

`default_nettype wire

// File: logic/req_fifo.sv
// ====================
// Request queue for one channel: a circular buffer whose head is
// visible one cycle after the push, with an almost-full level that
// becomes the client's ready
// ====================

`default_nettype none

module req_fifo
#(
    parameter type T                 = logic,
    parameter int  fifo_depth        = 8,
    parameter int  almost_full_slack = 2
)
(
    input  wire logic clk,
    input  wire logic reset,

    // Producer side
    input  wire logic push,
    input  wire T     push_data,

    // Consumer side
    input  wire logic pop,
    output T          head,
    output logic      not_empty,
    output logic      almost_full
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    // Entry storage, payload only
    T storage [fifo_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    logic do_push;
    logic do_pop;

    // A pop on an empty queue is ignored
    assign do_pop  = pop && not_empty;
    // A push into a full queue is dropped unless a pop frees a slot
    assign do_push = push && ((count != cnt_w'(fifo_depth)) || do_pop);

    // ====================
    // Pointers and count
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // Explicit wrap keeps a depth that is not a power of two working
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            storage[wr_ptr] <= push_data;
        end
    end

    // ====================
    // Status
    // ====================

    assign head      = storage[rd_ptr];
    assign not_empty = (count != '0);

    // Free slots at or below the slack raise almost_full
    assign almost_full = (count >= cnt_w'(fifo_depth - almost_full_slack));

endmodule

`default_nettype wire

// File: logic/mem_client_adapter.sv
// ====================
// Client side of the memory driver: turns the read and write enable
// strobes into pushes on the two request queues, folds the register
// block's force_order into every read and derives the ready levels
// ====================

`default_nettype none

module mem_client_adapter
    import ccx_mem_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,

    // Client read request
    input  wire logic    mem_read_req_enable,
    input  wire rd_req_t mem_read_req,
    output logic         mem_read_req_rdy,

    // Client write request
    input  wire logic    mem_write_enable,
    input  wire wr_req_t mem_write_req,
    output logic         mem_write_rdy,

    // Controls from the register block
    input  wire ctrl_t   ctrl,

    // Queue fullness
    input  wire logic    rd_almost_full,
    input  wire logic    wr_almost_full,

    // Queue pushes
    output logic         rd_push,
    output rd_req_t      rd_push_req,
    output logic         wr_push,
    output wr_req_t      wr_push_req
);

    // ====================
    // Ready levels
    // ====================

    // Both channels stay closed until software sets the enable bit
    // The queue's almost-full level leaves room for the client's
    // one-cycle reaction to a falling ready
    assign mem_read_req_rdy = ctrl.enable && !rd_almost_full;
    assign mem_write_rdy    = ctrl.enable && !wr_almost_full;

    // ====================
    // Read channel
    // ====================

    // A strobe that arrives against a low ready is not pushed, so a
    // misbehaving client cannot overrun the queue
    assign rd_push = mem_read_req_enable && mem_read_req_rdy;

    // Force ordering turns every read into an ordered one
    always_comb
    begin
        rd_push_req = mem_read_req;
        rd_push_req.check_order = mem_read_req.check_order || ctrl.force_order;
    end

    // ====================
    // Write channel
    // ====================

    // Writes always drain in order, so the header passes unchanged
    assign wr_push     = mem_write_enable && mem_write_rdy;
    assign wr_push_req = mem_write_req;

    // ====================
    // Protocol error flag
    // ====================

    // Sticky record of any strobe seen while its ready was low
    // It is cleared only by reset and is watched by the checker
    logic proto_err;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            proto_err <= 1'b0;
        end
        else if ((mem_read_req_enable && !mem_read_req_rdy) ||
                 (mem_write_enable && !mem_write_rdy))
        begin
            proto_err <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/line_mem.sv
// ====================
// Local cache-line memory that serves both request queues
// One write and one read may pop per cycle. The write lands first, so
// a read in the same cycle sees it. Responses come one cycle later.
// ====================

`default_nettype none

module line_mem
    import ccx_mem_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,

    // Read queue head
    input  wire rd_req_t rd_head,
    input  wire logic    rd_not_empty,

    // Write queue head
    input  wire wr_req_t wr_head,
    input  wire logic    wr_not_empty,

    // Pops back to the queues
    output logic         rd_pop,
    output logic         wr_pop,

    // Responses to the client
    output logic         mem_read_rsp_valid,
    output line_data_t   mem_read_rsp_data,
    output logic [1:0]   mem_write_ack
);

    // Line storage for all 64 lines
    line_data_t lines [2**line_addr_w];

    line_data_t rd_data;
    logic       rd_stall;

    // ====================
    // Pop decisions
    // ====================

    // Writes are never stalled, so the write queue drains one per cycle
    assign wr_pop = wr_not_empty;

    // An ordered read waits while any write is still queued or being
    // applied, which covers every write accepted ahead of it
    // Unordered reads go straight through
    assign rd_stall = rd_head.check_order && wr_not_empty;
    assign rd_pop   = rd_not_empty && !rd_stall;

    // ====================
    // Storage access
    // ====================

    // Within one cycle the write lands before the read, so a write
    // popping to the same line forwards its data to the read
    always_comb
    begin
        if (wr_pop && (wr_head.addr == rd_head.addr))
        begin
            rd_data = wr_head.data;
        end
        else
        begin
            rd_data = lines[rd_head.addr];
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_pop)
        begin
            lines[wr_head.addr] <= wr_head.data;
        end
    end

    // ====================
    // Responses
    // ====================

    // Read data is loaded on every pop
    always_ff @(posedge clk)
    begin
        if (rd_pop)
        begin
            mem_read_rsp_data <= rd_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_read_rsp_valid <= 1'b0;
            mem_write_ack      <= 2'd0;
        end
        else
        begin
            mem_read_rsp_valid <= rd_pop;
            // At most one write completes per cycle, so the count is 0 or 1
            mem_write_ack      <= {1'b0, wr_pop};
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_csr.sv
// ====================
// MMIO register block beside the adapter: control bits, two
// saturating completion counters and a registered read response
// A write to a counter offset clears that counter
// ====================

`default_nettype none

module mem_csr
    import ccx_mem_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,

    // MMIO request from the client
    input  wire logic      mmio_req_valid,
    input  wire mmio_req_t mmio_req,

    // Completions to count
    input  wire logic      mem_read_rsp_valid,
    input  wire logic [1:0] mem_write_ack,

    // Controls to the adapter
    output ctrl_t          ctrl,

    // Registered MMIO read response
    output logic           mmio_rsp_valid,
    output mmio_rsp_t      mmio_rsp
);

    logic [31:0] wr_ack_cnt;
    logic [31:0] rd_rsp_cnt;

    logic mmio_wr;
    logic mmio_rd;

    // Counter add that sticks at all ones instead of wrapping
    function automatic logic [31:0] sat_add(input logic [31:0] cnt, input logic [1:0] inc);
        logic [32:0] sum;
        sum = {1'b0, cnt} + 33'(inc);
        return sum[32] ? 32'hffff_ffff : sum[31:0];
    endfunction

    assign mmio_wr = mmio_req_valid && mmio_req.is_write;
    assign mmio_rd = mmio_req_valid && !mmio_req.is_write;

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl       <= '0;
            wr_ack_cnt <= '0;
            rd_rsp_cnt <= '0;
        end
        else
        begin
            // Only the two defined control bits are stored
            if (mmio_wr && (mmio_req.offset == csr_ctrl))
            begin
                ctrl.enable      <= mmio_req.wdata[0];
                ctrl.force_order <= mmio_req.wdata[1];
            end

            // A clearing write wins over a completion in the same cycle
            if (mmio_wr && (mmio_req.offset == csr_wr_acks))
                wr_ack_cnt <= '0;
            else
                wr_ack_cnt <= sat_add(wr_ack_cnt, mem_write_ack);

            if (mmio_wr && (mmio_req.offset == csr_rd_rsps))
                rd_rsp_cnt <= '0;
            else
                rd_rsp_cnt <= sat_add(rd_rsp_cnt, {1'b0, mem_read_rsp_valid});
        end
    end

    // ====================
    // Read response
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
            mmio_rsp_valid <= 1'b0;
        else
            mmio_rsp_valid <= mmio_rd;
    end

    // Unused offset 3 reads as zero
    always_ff @(posedge clk)
    begin
        if (mmio_rd)
        begin
            case (mmio_req.offset)
                csr_ctrl:    mmio_rsp.data <= ctrl;
                csr_wr_acks: mmio_rsp.data <= wr_ack_cnt;
                csr_rd_rsps: mmio_rsp.data <= rd_rsp_cnt;
                default:     mmio_rsp.data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_subsys_top.sv
// ====================
// Top of the memory subsystem: adapter, read and write request
// queues, line memory and register block. Queue sizing is set here
// and passed down to both queues.
// ====================

`default_nettype none

module mem_subsys_top
    import ccx_mem_pkg::*;
#(
    parameter int fifo_depth        = 8,
    parameter int almost_full_slack = 2
)
(
    input  wire logic      clk,
    input  wire logic      reset,

    // Read channel
    input  wire logic      mem_read_req_enable,
    input  wire rd_req_t   mem_read_req,
    output logic           mem_read_req_rdy,
    output logic           mem_read_rsp_valid,
    output line_data_t     mem_read_rsp_data,

    // Write channel
    input  wire logic      mem_write_enable,
    input  wire wr_req_t   mem_write_req,
    output logic           mem_write_rdy,
    output logic [1:0]     mem_write_ack,

    // MMIO
    input  wire logic      mmio_req_valid,
    input  wire mmio_req_t mmio_req,
    output logic           mmio_rsp_valid,
    output mmio_rsp_t      mmio_rsp
);

    ctrl_t   ctrl;

    // Queue traffic
    logic    rd_push;
    rd_req_t rd_push_req;
    rd_req_t rd_head;
    logic    rd_pop;
    logic    rd_not_empty;
    logic    rd_almost_full;

    logic    wr_push;
    wr_req_t wr_push_req;
    wr_req_t wr_head;
    logic    wr_pop;
    logic    wr_not_empty;
    logic    wr_almost_full;

    // ====================
    // Client adapter
    // ====================

    mem_client_adapter adapter_i (
        .clk, .reset,
        .mem_read_req_enable, .mem_read_req, .mem_read_req_rdy,
        .mem_write_enable, .mem_write_req, .mem_write_rdy,
        .ctrl, .rd_almost_full, .wr_almost_full,
        .rd_push, .rd_push_req, .wr_push, .wr_push_req
    );

    // ====================
    // Request queues
    // ====================

    req_fifo #(.T(rd_req_t), .fifo_depth(fifo_depth), .almost_full_slack(almost_full_slack))
    rd_fifo_i (
        .clk, .reset,
        .push(rd_push), .push_data(rd_push_req), .pop(rd_pop),
        .head(rd_head), .not_empty(rd_not_empty), .almost_full(rd_almost_full)
    );

    req_fifo #(.T(wr_req_t), .fifo_depth(fifo_depth), .almost_full_slack(almost_full_slack))
    wr_fifo_i (
        .clk, .reset,
        .push(wr_push), .push_data(wr_push_req), .pop(wr_pop),
        .head(wr_head), .not_empty(wr_not_empty), .almost_full(wr_almost_full)
    );

    // ====================
    // Line memory and registers
    // ====================

    line_mem line_mem_i (
        .clk, .reset,
        .rd_head, .rd_not_empty, .wr_head, .wr_not_empty,
        .rd_pop, .wr_pop,
        .mem_read_rsp_valid, .mem_read_rsp_data, .mem_write_ack
    );

    mem_csr mem_csr_i (
        .clk, .reset,
        .mmio_req_valid, .mmio_req,
        .mem_read_rsp_valid, .mem_write_ack,
        .ctrl, .mmio_rsp_valid, .mmio_rsp
    );

endmodule

`default_nettype wire

// File: dv/mem_subsys_chk.sv
// ====================
// Assertions on the client strobe rules, the reset state of the
// responses and the MMIO read latency. Bound into the subsystem top
// so the adapter ports and the response outputs are seen together
// ====================

`default_nettype none

module mem_subsys_chk
    import ccx_mem_pkg::*;
(
    input wire logic       clk,
    input wire logic       reset,
    input wire logic       mem_read_req_enable,
    input wire logic       mem_read_req_rdy,
    input wire logic       mem_write_enable,
    input wire logic       mem_write_rdy,
    input wire logic       proto_err,
    input wire logic       mem_read_rsp_valid,
    input wire logic [1:0] mem_write_ack,
    input wire logic       mmio_req_valid,
    input wire mmio_req_t  mmio_req,
    input wire logic       mmio_rsp_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed assertions, watched by the testbench monitor
    int fail_count = 0;

    // A client strobe is only legal while its channel is ready
    a_rd_strobe: assert property (@(posedge clk) disable iff (reset)
        mem_read_req_enable |-> mem_read_req_rdy)
        else
        begin
            $error("read enable seen while mem_read_req_rdy is low");
            fail_count++;
        end

    a_wr_strobe: assert property (@(posedge clk) disable iff (reset)
        mem_write_enable |-> mem_write_rdy)
        else
        begin
            $error("write enable seen while mem_write_rdy is low");
            fail_count++;
        end

    // The adapter's sticky flag must never be raised
    a_proto_flag: assert property (@(posedge clk) disable iff (reset) !proto_err)
        else
        begin
            $error("adapter recorded a protocol error");
            fail_count++;
        end

    // One cycle into reset every response is quiet
    a_reset_quiet: assert property (@(posedge clk)
        reset |=> (!mem_read_rsp_valid && (mem_write_ack == 2'd0) && !mmio_rsp_valid))
        else
        begin
            $error("response active during reset");
            fail_count++;
        end

    // An MMIO read answers in exactly the next cycle
    a_mmio_latency: assert property (@(posedge clk) disable iff (reset)
        (mmio_req_valid && !mmio_req.is_write) |=> mmio_rsp_valid)
        else
        begin
            $error("MMIO read without a response in the next cycle");
            fail_count++;
        end

endmodule

bind mem_subsys_top mem_subsys_chk chk_i (
    .clk, .reset,
    .mem_read_req_enable, .mem_read_req_rdy,
    .mem_write_enable, .mem_write_rdy,
    .proto_err(adapter_i.proto_err),
    .mem_read_rsp_valid, .mem_write_ack,
    .mmio_req_valid, .mmio_req, .mmio_rsp_valid
);

`default_nettype wire

// File: dv/mem_subsys_tb.sv
// ====================
// Testbench for the memory subsystem. Random traffic from an LCG is
// checked against a line model, with ordered reads, a back-pressure
// burst and the MMIO completion counters
// ====================

`default_nettype none

module mem_subsys_tb
    import ccx_mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int fifo_depth        = 8;
    localparam int almost_full_slack = 2;

    localparam int n_fill  = 64;
    localparam int n_rand  = 32;
    localparam int n_order = 8;
    localparam int n_burst = 40;
    // Upper bound on all requests including the MMIO accesses
    localparam int n_reqs      = n_fill + 2 * n_rand + 2 * n_order * 4 + 2 * n_burst + 16;
    localparam int cycle_limit = 20 * n_reqs;

    logic       clk;
    logic       reset;
    logic       rd_en;
    rd_req_t    rd_req;
    logic       rd_rdy;
    logic       rd_rsp_valid;
    line_data_t rd_rsp_data;
    logic       wr_en;
    wr_req_t    wr_req;
    logic       wr_rdy;
    logic [1:0] wr_ack;
    logic       mmio_valid;
    mmio_req_t  mmio_req;
    logic       mmio_rsp_valid;
    mmio_rsp_t  mmio_rsp;

    // Line model that is updated in write-completion order
    line_data_t  model_lines [64];
    wr_req_t     wr_pending [$];
    line_data_t  rd_expected [$];
    logic [31:0] lcg_state;
    int          wr_sent;
    int          rd_sent;
    int          ack_count;
    int          rsp_count;
    int          cycle_count;
    int          error_count;
    logic        wr_taken;
    logic        rd_taken;

    mem_subsys_top #(
        .fifo_depth(fifo_depth),
        .almost_full_slack(almost_full_slack)
    ) dut_i (
        .clk(clk), .reset(reset),
        .mem_read_req_enable(rd_en), .mem_read_req(rd_req), .mem_read_req_rdy(rd_rdy),
        .mem_read_rsp_valid(rd_rsp_valid), .mem_read_rsp_data(rd_rsp_data),
        .mem_write_enable(wr_en), .mem_write_req(wr_req), .mem_write_rdy(wr_rdy),
        .mem_write_ack(wr_ack),
        .mmio_req_valid(mmio_valid), .mmio_req(mmio_req),
        .mmio_rsp_valid(mmio_rsp_valid), .mmio_rsp(mmio_rsp)
    );

    always #10 clk = ~clk;

    // ====================
    // Helpers
    // ====================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper LCG bits are the better random ones
    function automatic line_addr_t rand_addr();
        return line_addr_t'(lcg_next() >> 16);
    endfunction

    function automatic line_data_t rand_line();
        return {lcg_next(), lcg_next()};
    endfunction

    // Newest value of a line counting the writes not yet acknowledged
    function automatic line_data_t model_read(input line_addr_t addr);
        line_data_t data;
        data = model_lines[addr];
        foreach (wr_pending[i])
        begin
            if (wr_pending[i].addr == addr)
                data = wr_pending[i].data;
        end
        return data;
    endfunction

    task automatic stop_on_error(input string what);
        error_count++;
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_line(input string name, input line_data_t exp, input line_data_t got);
        if (got !== exp)
            stop_on_error($sformatf("error %s exp %h got %h", name, exp, got));
    endtask

    task automatic compare_ack(input string name, input logic [1:0] exp, input logic [1:0] got);
        if (got !== exp)
            stop_on_error($sformatf("error %s exp %h got %h", name, exp, got));
    endtask

    task automatic compare_mmio(input string name, input mmio_rsp_t exp, input mmio_rsp_t got);
        if (got !== exp)
            stop_on_error($sformatf("error %s exp %h got %h", name, exp, got));
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic got);
        if (got !== exp)
            stop_on_error($sformatf("error %s exp %h got %h", name, exp, got));
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_drive_point();
        @(posedge clk);
        #2;
    endtask

    // One cycle of client traffic where each strobe is only raised against a high ready
    task automatic drive_cycle(input logic want_wr, input wr_req_t w,
                               input logic want_rd, input rd_req_t r);
        wr_taken = want_wr && wr_rdy;
        rd_taken = want_rd && rd_rdy;
        wr_en    = wr_taken;
        wr_req   = w;
        rd_en    = rd_taken;
        rd_req   = r;
        // The write goes into the model first so that a same-cycle read sees it
        if (wr_taken)
        begin
            wr_pending.push_back(w);
            wr_sent++;
        end
        if (rd_taken)
        begin
            rd_expected.push_back(model_read(r.addr));
            rd_sent++;
        end
        next_drive_point();
        wr_en = 1'b0;
        rd_en = 1'b0;
    endtask

    task automatic write_line(input line_addr_t addr, input line_data_t data);
        wr_req_t w;
        w = '{addr: addr, data: data, check_order: 1'b0};
        wr_taken = 1'b0;
        while (!wr_taken)
            drive_cycle(1'b1, w, 1'b0, '0);
    endtask

    task automatic read_line(input line_addr_t addr, input logic ordered);
        rd_req_t r;
        r = '{addr: addr, check_order: ordered};
        rd_taken = 1'b0;
        while (!rd_taken)
            drive_cycle(1'b0, '0, 1'b1, r);
    endtask

    task automatic wait_drain();
        while ((wr_pending.size() != 0) || (rd_expected.size() != 0))
            next_drive_point();
    endtask

    task automatic mmio_write(input logic [1:0] offset, input logic [31:0] data);
        mmio_valid = 1'b1;
        mmio_req   = '{offset: offset, wdata: data, is_write: 1'b1};
        next_drive_point();
        mmio_valid = 1'b0;
    endtask

    task automatic mmio_read_check(input logic [1:0] offset, input logic [31:0] exp);
        mmio_rsp_t want;
        want.data  = exp;
        mmio_valid = 1'b1;
        mmio_req   = '{offset: offset, wdata: 32'h0, is_write: 1'b0};
        next_drive_point();
        mmio_valid = 1'b0;
        compare_bit("mmio_rsp_valid", 1'b1, mmio_rsp_valid);
        compare_mmio("mmio_rsp", want, mmio_rsp);
    endtask

    // ====================
    // Monitor and timeout
    // ====================

    // Outputs are sampled on the falling edge while they are stable
    always @(negedge clk)
    begin
        wr_req_t done;
        if (!reset)
        begin
            if (rd_rsp_valid)
            begin
                if (rd_expected.size() == 0)
                    stop_on_error("a read response arrived with no read outstanding");
                compare_line("mem_read_rsp_data", rd_expected.pop_front(), rd_rsp_data);
                rsp_count++;
            end
            if (wr_ack != 2'd0)
            begin
                if (wr_pending.size() == 0)
                    stop_on_error("a write acknowledge arrived with no write outstanding");
                compare_ack("mem_write_ack", 2'd1, wr_ack);
                done = wr_pending.pop_front();
                model_lines[done.addr] = done.data;
                ack_count += int'(wr_ack);
            end
            if (dut_i.chk_i.fail_count != 0)
                stop_on_error("an assertion in the bound checker failed");
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
            stop_on_error($sformatf("timeout after %0d cycles with tests unfinished", cycle_count));
    end

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        line_addr_t a;
        wr_req_t    w;
        rd_req_t    r;
        int         nw;
        int         burst_rds;
        logic       saw_rd_low;

        clk         = 1'b0;
        reset       = 1'b1;
        rd_en       = 1'b0;
        rd_req      = '0;
        wr_en       = 1'b0;
        wr_req      = '0;
        mmio_valid  = 1'b0;
        mmio_req    = '0;
        lcg_state   = 32'haa2d_63ee;
        wr_sent     = 0;
        rd_sent     = 0;
        ack_count   = 0;
        rsp_count   = 0;
        cycle_count = 0;
        error_count = 0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        // Channels stay closed until the enable bit is written
        next_drive_point();
        compare_bit("mem_read_req_rdy", 1'b0, rd_rdy);
        compare_bit("mem_write_rdy", 1'b0, wr_rdy);
        mmio_write(csr_ctrl, 32'h1);
        compare_bit("mem_read_req_rdy", 1'b1, rd_rdy);
        compare_bit("mem_write_rdy", 1'b1, wr_rdy);
        mmio_read_check(csr_ctrl, 32'h1);

        // Fill every line so that no read sees an unwritten one
        for (int i = 0; i < n_fill; i++)
            write_line(line_addr_t'(i), {lcg_next(), 26'h0, line_addr_t'(i)});
        for (int i = 0; i < n_rand; i++)
            write_line(rand_addr(), rand_line());
        wait_drain();
        for (int i = 0; i < n_rand; i++)
            read_line(rand_addr(), 1'b0);
        wait_drain();

        // Ordered read in the same cycle as the last write to its line
        // The first round orders by the read's own bit and the second by force_order alone
        for (int round = 0; round < 2; round++)
        begin
            if (round == 1)
                mmio_write(csr_ctrl, 32'h3);
            for (int i = 0; i < n_order; i++)
            begin
                a  = rand_addr();
                nw = 1 + int'((lcg_next() >> 16) % 3);
                for (int j = 1; j < nw; j++)
                    write_line(a, rand_line());
                w = '{addr: a, data: rand_line(), check_order: 1'b0};
                r = '{addr: a, check_order: (round == 0)};
                drive_cycle(1'b1, w, 1'b1, r);
                if (!wr_taken || !rd_taken)
                    stop_on_error("an ordered read and its write were not taken together");
                // The ordered read holds while its write is applied, so no
                // response comes back in the cycle of that write's acknowledge
                next_drive_point();
                compare_bit("mem_read_rsp_valid", 1'b0, rd_rsp_valid);
                wait_drain();
            end
        end
        mmio_write(csr_ctrl, 32'h1);

        // Streaming writes to the low half keep an ordered read stalled,
        // so the reads to the upper half pile up behind it
        saw_rd_low = 1'b0;
        burst_rds  = 0;
        for (int i = 0; i < n_burst; i++)
        begin
            if (!rd_rdy)
                saw_rd_low = 1'b1;
            a    = rand_addr();
            a[5] = 1'b0;
            w    = '{addr: a, data: rand_line(), check_order: 1'b0};
            a    = rand_addr();
            a[5] = 1'b1;
            r    = '{addr: a, check_order: (burst_rds == 0)};
            drive_cycle(1'b1, w, 1'b1, r);
            if (rd_taken)
                burst_rds++;
        end
        if (!saw_rd_low)
            stop_on_error("read ready never dropped during the burst");
        // Nothing pops behind the stalled read, so ready falls once the
        // queue holds all but the slack entries
        if (burst_rds != fifo_depth - almost_full_slack)
            stop_on_error("read ready did not drop at the almost-full level");
        wait_drain();
        if ((rsp_count != rd_sent) || (ack_count != wr_sent))
            stop_on_error("a request was lost, completions do not match requests sent");

        // Read the completion counters and then clear them
        mmio_read_check(csr_wr_acks, 32'(ack_count));
        mmio_read_check(csr_rd_rsps, 32'(rsp_count));
        mmio_write(csr_wr_acks, 32'hffff_ffff);
        mmio_write(csr_rd_rsps, 32'h0);
        mmio_read_check(csr_wr_acks, 32'h0);
        mmio_read_check(csr_rd_rsps, 32'h0);

        if (error_count == 0)
        begin
            $display("All tests passed");
            $finish;
        end
        else
        begin
            stop_on_error("errors were recorded during the run");
        end
    end

endmodule

`default_nettype wire

// File: build.f
logic/ccx_mem_pkg.sv
logic/req_fifo.sv
logic/mem_client_adapter.sv
logic/line_mem.sv
logic/mem_csr.sv
logic/mem_subsys_top.sv
dv/mem_subsys_chk.sv
dv/mem_subsys_tb.sv

// File: Makefile
# Verilator build and run for the client memory subsystem testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The verdict comes from the log, so the simulator's own status is not used
run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
